// ==== Makefile ====
SIM := obj_dir/Vtb_top

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): list.f $(wildcard src/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_top --Mdir obj_dir -f list.f

# pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/commit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_checker #(
    parameter core_cfg_pkg::addr_t BOOT_PC = 32'h1c00_0000
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // fetch port, watched only
    input  wire                    wb_cyc_i,
    input  wire                    wb_stb_i,
    input  core_cfg_pkg::addr_t    wb_adr_i,
    input  core_cfg_pkg::word_t    wb_dat_i,
    input  wire                    wb_ack_i,
    // commit trace from the dut
    input  wire                    commit_valid_i,
    input  core_cfg_pkg::addr_t    commit_pc_i,
    input  core_cfg_pkg::word_t    commit_inst_i,
    input  wire                    commit_wen_i,
    input  core_cfg_pkg::reg_idx_t commit_wnum_i,
    input  core_cfg_pkg::word_t    commit_wdata_i,
    // running totals
    output int unsigned            commit_count_o,
    output int unsigned            error_count_o
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    // ack sampled at edge n, commit sampled at edge n+3
    localparam int unsigned COMMIT_LAG = 3;

    // fetches still in flight, oldest first
    addr_t       fetch_adr_q[$];
    word_t       fetch_word_q[$];
    int unsigned fetch_edge_q[$];

    word_t       model_regs[REG_COUNT];
    addr_t       model_pc;
    int unsigned edge_count;
    int unsigned commits;
    int unsigned errors;

    assign commit_count_o = commits;
    assign error_count_o  = errors;

    initial begin
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        model_pc   = BOOT_PC;
        edge_count = 0;
        commits    = 0;
        errors     = 0;
    end

    function automatic void check_field(string name, word_t got, word_t exp, addr_t pc);
        if (got !== exp) begin
            $display("error %s: got 0x%h, expected 0x%h at pc 0x%h", name, got, exp, pc);
            errors++;
        end
    endfunction

    task automatic check_commit();
        addr_t       adr;
        word_t       inst;
        int unsigned ack_edge;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        word_t       src_a;
        word_t       src_b;
        word_t       result;
        logic        known;
        logic        exp_wen;
        if (fetch_adr_q.size() == 0) begin
            $display("commit at pc 0x%h has no acknowledged fetch behind it", commit_pc_i);
            errors++;
        end else begin
            adr      = fetch_adr_q.pop_front();
            inst     = fetch_word_q.pop_front();
            ack_edge = fetch_edge_q.pop_front();
            // field positions of the 3R, 2RI12 and 1RI20 formats
            rd     = inst[4:0];
            rj     = inst[9:5];
            rk     = inst[14:10];
            src_a  = model_regs[rj];
            src_b  = model_regs[rk];
            known  = 1'b1;
            result = '0;
            if (inst[31:22] == OPC_ADDI) begin
                result = src_a + {{20{inst[21]}}, inst[21:10]};
            end else if (inst[31:25] == OPC_LU12I) begin
                result = {inst[24:5], 12'h000};
            end else begin
                case (inst[31:15])
                    OPC3R_ADD: result = src_a + src_b;
                    OPC3R_SUB: result = src_a - src_b;
                    OPC3R_AND: result = src_a & src_b;
                    OPC3R_OR:  result = src_a | src_b;
                    OPC3R_XOR: result = src_a ^ src_b;
                    default:   known  = 1'b0;
                endcase
            end
            // unknown words and r0 targets commit without a write
            exp_wen = known && (rd != '0);
            if (edge_count - ack_edge != COMMIT_LAG) begin
                $display("commit at pc 0x%h came %0d edges after its ack instead of %0d",
                         commit_pc_i, edge_count - ack_edge, COMMIT_LAG);
                errors++;
            end
            check_field("wb_adr_o", adr, model_pc, model_pc);
            check_field("commit_pc_o", commit_pc_i, model_pc, model_pc);
            check_field("commit_inst_o", commit_inst_i, inst, model_pc);
            check_field("commit_wen_o", word_t'(commit_wen_i), word_t'(exp_wen), model_pc);
            check_field("commit_wnum_o", word_t'(commit_wnum_i), word_t'(rd), model_pc);
            if (exp_wen) begin
                check_field("commit_wdata_o", commit_wdata_i, result, model_pc);
                model_regs[rd] = result;
            end
            model_pc = model_pc + 32'd4;
            commits++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            if (commit_valid_i !== 1'b0) begin
                $display("commit_valid_o not low while reset is asserted");
                errors++;
            end
        end else begin
            edge_count++;
            // transfer happens at the edge where ack is sampled
            if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
                fetch_adr_q.push_back(wb_adr_i);
                fetch_word_q.push_back(wb_dat_i);
                fetch_edge_q.push_back(edge_count);
            end
            if (commit_valid_i) begin
                check_commit();
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_properties (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // wishbone fetch port as seen at the core boundary
    input  wire                    wb_cyc_o,
    input  wire                    wb_stb_o,
    input  core_cfg_pkg::addr_t    wb_adr_o,
    input  wire                    wb_ack_i,
    // commit trace
    input  wire                    commit_valid_o,
    input  wire                    commit_wen_o,
    input  core_cfg_pkg::reg_idx_t commit_wnum_o
);

    // failed assertions, read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // strobe only inside a bus cycle
    stb_within_cyc: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_stb_o |-> wb_cyc_o
    ) else begin
        fail_count++;
        $error("wb_stb_o high while wb_cyc_o low");
    end

    // open request held with the same address until ack
    request_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && wb_cyc_o && $stable(wb_adr_o))
    ) else begin
        fail_count++;
        $error("wishbone request dropped or address changed before ack");
    end

    // r0 is never a write target
    commit_wnum_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        commit_wen_o |-> (commit_wnum_o != '0)
    ) else begin
        fail_count++;
        $error("commit_wen_o high with commit_wnum_o zero");
    end

    // commit visible from edge N+2, so sampled three edges after the ack
    commit_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        commit_valid_o == $past(wb_cyc_o && wb_stb_o && wb_ack_i, 3)
    ) else begin
        fail_count++;
        $error("commit_valid_o out of step with the acknowledged fetches");
    end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import core_cfg_pkg::*;
    import isa_pkg::*;

    localparam addr_t       BOOT_PC     = 32'h1c00_0000;
    localparam int unsigned NUM_COMMITS = 400;
    // cycles the fetch unit may take to raise a request
    localparam int unsigned REQ_TIMEOUT = 20;
    // fetches allowed before the commit count must be reached
    localparam int unsigned FETCH_LIMIT = NUM_COMMITS + 20;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    addr_t       wb_adr;
    word_t       wb_dat;
    logic        wb_ack;
    logic        commit_valid;
    addr_t       commit_pc;
    word_t       commit_inst;
    logic        commit_wen;
    reg_idx_t    commit_wnum;
    word_t       commit_wdata;
    int unsigned commit_count;
    int unsigned error_count;

    always #5 clk = ~clk;

    core_top #(
        .BOOT_PC (BOOT_PC)
    ) core_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_adr_o       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_ack_i       (wb_ack),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc),
        .commit_inst_o  (commit_inst),
        .commit_wen_o   (commit_wen),
        .commit_wnum_o  (commit_wnum),
        .commit_wdata_o (commit_wdata)
    );

    commit_checker #(
        .BOOT_PC (BOOT_PC)
    ) commit_checker_inst (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_ack_i       (wb_ack),
        .commit_valid_i (commit_valid),
        .commit_pc_i    (commit_pc),
        .commit_inst_i  (commit_inst),
        .commit_wen_i   (commit_wen),
        .commit_wnum_i  (commit_wnum),
        .commit_wdata_i (commit_wdata),
        .commit_count_o (commit_count),
        .error_count_o  (error_count)
    );

    bind core_top core_properties core_properties_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_adr_o       (wb_adr_o),
        .wb_ack_i       (wb_ack_i),
        .commit_valid_o (commit_valid_o),
        .commit_wen_o   (commit_wen_o),
        .commit_wnum_o  (commit_wnum_o)
    );

    // mostly r0..r7, so neighbouring instructions share registers
    function automatic reg_idx_t pick_reg();
        reg_idx_t r;
        if ($urandom % 4 != 0) begin
            r = reg_idx_t'($urandom % 8);
        end else begin
            r = reg_idx_t'($urandom);
        end
        return r;
    endfunction

    // subset encodings with random fields, now and then a raw word
    function automatic word_t make_inst();
        word_t       inst;
        int unsigned kind;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        kind = $urandom % 16;
        rd   = pick_reg();
        rj   = pick_reg();
        rk   = pick_reg();
        case (kind)
            0, 1, 2:  inst = {OPC3R_ADD, rk, rj, rd};
            3, 4:     inst = {OPC3R_SUB, rk, rj, rd};
            5:        inst = {OPC3R_AND, rk, rj, rd};
            6:        inst = {OPC3R_OR, rk, rj, rd};
            7:        inst = {OPC3R_XOR, rk, rj, rd};
            8, 9, 10: inst = {OPC_ADDI, 12'($urandom), rj, rd};
            11, 12:   inst = {OPC_LU12I, 20'($urandom), rd};
            default:  inst = $urandom;
        endcase
        return inst;
    endfunction

    // one wishbone read, called 1 ns after a rising edge
    task automatic serve_fetch(output bit ok);
        int unsigned n;
        int unsigned wait_cycles;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < REQ_TIMEOUT) begin
            if (wb_cyc && wb_stb) begin
                ok = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                n++;
            end
        end
        if (!ok) begin
            $display("timeout: fetch unit raised no request within %0d cycles", REQ_TIMEOUT);
        end else begin
            // zero waits favoured for back-to-back dependencies
            wait_cycles = ($urandom % 2 == 0) ? 0 : $urandom % 4;
            repeat (wait_cycles) begin
                @(posedge clk);
                #1;
            end
            wb_dat = make_inst();
            wb_ack = 1'b1;
            @(posedge clk);
            #1;
            wb_ack = 1'b0;
            // garbage on the bus outside the ack cycle
            wb_dat = $urandom;
        end
    endtask

    initial begin
        int unsigned fetches;
        int unsigned assert_fails;
        bit          ok;
        clk    = 1'b0;
        rst_n  = 1'b0;
        wb_ack = 1'b0;
        wb_dat = '0;
        void'($urandom(8297));
        repeat (8) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        fetches = 0;
        ok      = 1'b1;
        while (ok && commit_count < NUM_COMMITS) begin
            if (fetches >= FETCH_LIMIT) begin
                $display("timeout: only %0d commits after %0d fetches", commit_count, fetches);
                ok = 1'b0;
            end else begin
                serve_fetch(ok);
                fetches++;
            end
        end
        assert_fails = core_top_inst.core_properties_inst.fail_count;
        $display("commits %0d, checker errors %0d, assertion failures %0d, timeouts %0d",
                 commit_count, error_count, assert_fails, ok ? 0 : 1);
        if (ok && error_count == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/core_cfg_pkg.sv
src/isa_pkg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/result_stage.sv
src/core_top.sv
dv/core_properties.sv
dv/commit_checker.sv
dv/tb_top.sv

// ==== src/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

    // architectural widths
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 5;

    // general registers r0..r31, r0 hardwired to zero
    localparam int REG_COUNT = 32;

    // one data word as held in a register
    typedef logic [DATA_WIDTH-1:0] word_t;

    // byte address, pc and bus address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // register number as found in rd, rj, rk
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter core_cfg_pkg::addr_t BOOT_PC = 32'h1c00_0000
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // wishbone instruction port
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output core_cfg_pkg::addr_t    wb_adr_o,
    input  core_cfg_pkg::word_t    wb_dat_i,
    input  wire                    wb_ack_i,
    // commit trace
    output logic                   commit_valid_o,
    output core_cfg_pkg::addr_t    commit_pc_o,
    output core_cfg_pkg::word_t    commit_inst_o,
    output logic                   commit_wen_o,
    output core_cfg_pkg::reg_idx_t commit_wnum_o,
    output core_cfg_pkg::word_t    commit_wdata_o
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    // fetch to decode
    logic     fetch_valid;
    addr_t    fetch_pc;
    word_t    fetch_inst;

    // decode to register file
    reg_idx_t rf_raddr_a;
    reg_idx_t rf_raddr_b;
    word_t    rf_rdata_a;
    word_t    rf_rdata_b;

    // decode to execute
    logic     dec_valid;
    addr_t    dec_pc;
    word_t    dec_inst;
    logic     dec_wen;
    reg_idx_t dec_wnum;
    alu_op_e  dec_op;
    word_t    dec_opa;
    word_t    dec_opb;

    // execute bypass and outputs
    logic     ex_fwd_valid;
    logic     ex_fwd_wen;
    reg_idx_t ex_fwd_wnum;
    word_t    ex_fwd_data;
    logic     ex_valid;
    addr_t    ex_pc;
    word_t    ex_inst;
    logic     ex_wen;
    reg_idx_t ex_wnum;
    word_t    ex_result;

    // result bypass and write port
    logic     res_fwd_valid;
    logic     res_fwd_wen;
    reg_idx_t res_fwd_wnum;
    word_t    res_fwd_data;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    fetch_unit #(
        .BOOT_PC (BOOT_PC)
    ) fetch_unit_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc),
        .fetch_inst_o  (fetch_inst)
    );

    decode_stage decode_stage_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_valid_i   (fetch_valid),
        .fetch_pc_i      (fetch_pc),
        .fetch_inst_i    (fetch_inst),
        .rf_raddr_a_o    (rf_raddr_a),
        .rf_raddr_b_o    (rf_raddr_b),
        .rf_rdata_a_i    (rf_rdata_a),
        .rf_rdata_b_i    (rf_rdata_b),
        .ex_fwd_valid_i  (ex_fwd_valid),
        .ex_fwd_wen_i    (ex_fwd_wen),
        .ex_fwd_wnum_i   (ex_fwd_wnum),
        .ex_fwd_data_i   (ex_fwd_data),
        .res_fwd_valid_i (res_fwd_valid),
        .res_fwd_wen_i   (res_fwd_wen),
        .res_fwd_wnum_i  (res_fwd_wnum),
        .res_fwd_data_i  (res_fwd_data),
        .dec_valid_o     (dec_valid),
        .dec_pc_o        (dec_pc),
        .dec_inst_o      (dec_inst),
        .dec_wen_o       (dec_wen),
        .dec_wnum_o      (dec_wnum),
        .dec_op_o        (dec_op),
        .dec_opa_o       (dec_opa),
        .dec_opb_o       (dec_opb)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dec_valid_i    (dec_valid),
        .dec_pc_i       (dec_pc),
        .dec_inst_i     (dec_inst),
        .dec_wen_i      (dec_wen),
        .dec_wnum_i     (dec_wnum),
        .dec_op_i       (dec_op),
        .dec_opa_i      (dec_opa),
        .dec_opb_i      (dec_opb),
        .ex_fwd_valid_o (ex_fwd_valid),
        .ex_fwd_wen_o   (ex_fwd_wen),
        .ex_fwd_wnum_o  (ex_fwd_wnum),
        .ex_fwd_data_o  (ex_fwd_data),
        .ex_valid_o     (ex_valid),
        .ex_pc_o        (ex_pc),
        .ex_inst_o      (ex_inst),
        .ex_wen_o       (ex_wen),
        .ex_wnum_o      (ex_wnum),
        .ex_result_o    (ex_result)
    );

    result_stage result_stage_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ex_valid_i      (ex_valid),
        .ex_pc_i         (ex_pc),
        .ex_inst_i       (ex_inst),
        .ex_wen_i        (ex_wen),
        .ex_wnum_i       (ex_wnum),
        .ex_result_i     (ex_result),
        .res_fwd_valid_o (res_fwd_valid),
        .res_fwd_wen_o   (res_fwd_wen),
        .res_fwd_wnum_o  (res_fwd_wnum),
        .res_fwd_data_o  (res_fwd_data),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .commit_valid_o  (commit_valid_o),
        .commit_pc_o     (commit_pc_o),
        .commit_inst_o   (commit_inst_o),
        .commit_wen_o    (commit_wen_o),
        .commit_wnum_o   (commit_wnum_o),
        .commit_wdata_o  (commit_wdata_o)
    );

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // from fetch
    input  wire                    fetch_valid_i,
    input  core_cfg_pkg::addr_t    fetch_pc_i,
    input  core_cfg_pkg::word_t    fetch_inst_i,
    // register file read ports
    output core_cfg_pkg::reg_idx_t rf_raddr_a_o,
    output core_cfg_pkg::reg_idx_t rf_raddr_b_o,
    input  core_cfg_pkg::word_t    rf_rdata_a_i,
    input  core_cfg_pkg::word_t    rf_rdata_b_i,
    // bypass from execute
    input  wire                    ex_fwd_valid_i,
    input  wire                    ex_fwd_wen_i,
    input  core_cfg_pkg::reg_idx_t ex_fwd_wnum_i,
    input  core_cfg_pkg::word_t    ex_fwd_data_i,
    // bypass from result
    input  wire                    res_fwd_valid_i,
    input  wire                    res_fwd_wen_i,
    input  core_cfg_pkg::reg_idx_t res_fwd_wnum_i,
    input  core_cfg_pkg::word_t    res_fwd_data_i,
    // to execute
    output logic                   dec_valid_o,
    output core_cfg_pkg::addr_t    dec_pc_o,
    output core_cfg_pkg::word_t    dec_inst_o,
    output logic                   dec_wen_o,
    output core_cfg_pkg::reg_idx_t dec_wnum_o,
    output isa_pkg::alu_op_e       dec_op_o,
    output core_cfg_pkg::word_t    dec_opa_o,
    output core_cfg_pkg::word_t    dec_opb_o
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    logic    valid_q;
    addr_t   pc_q;
    word_t   inst_q;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    alu_op_e op;
    logic    known;
    logic    use_rk;
    word_t   imm;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_valid_i;
        end
    end

    // instruction payload, loaded on each fetch
    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            pc_q   <= fetch_pc_i;
            inst_q <= fetch_inst_i;
        end
    end

    assign rd = inst_q[4:0];
    assign rj = inst_q[9:5];
    assign rk = inst_q[14:10];

    // opcode match, 3R formats last
    always_comb begin
        op     = ALU_ADD;
        known  = 1'b1;
        use_rk = 1'b0;
        imm    = '0;
        if (inst_q[31:22] == OPC_ADDI) begin
            // si12 sign extended
            imm = {{20{inst_q[21]}}, inst_q[21:10]};
        end else if (inst_q[31:25] == OPC_LU12I) begin
            op  = ALU_LUI;
            // si20 into the upper bits
            imm = {inst_q[24:5], 12'h000};
        end else begin
            use_rk = 1'b1;
            case (inst_q[31:15])
                OPC3R_ADD: op = ALU_ADD;
                OPC3R_SUB: op = ALU_SUB;
                OPC3R_AND: op = ALU_AND;
                OPC3R_OR:  op = ALU_OR;
                OPC3R_XOR: op = ALU_XOR;
                default:   known = 1'b0;
            endcase
        end
    end

    // youngest producer wins, register file last
    function automatic word_t fwd_sel(input reg_idx_t idx, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (res_fwd_valid_i && res_fwd_wen_i && res_fwd_wnum_i == idx) begin
            val = res_fwd_data_i;
        end
        if (ex_fwd_valid_i && ex_fwd_wen_i && ex_fwd_wnum_i == idx) begin
            val = ex_fwd_data_i;
        end
        return val;
    endfunction

    assign rf_raddr_a_o = rj;
    assign rf_raddr_b_o = rk;

    assign dec_valid_o = valid_q;
    assign dec_pc_o    = pc_q;
    assign dec_inst_o  = inst_q;
    // no write for r0 or unknown encodings
    assign dec_wen_o   = valid_q & known & (rd != '0);
    assign dec_wnum_o  = rd;
    assign dec_op_o    = op;

    // operands follow the bypass inputs as well as the register numbers
    always_comb begin
        dec_opa_o = fwd_sel(rj, rf_rdata_a_i);
        dec_opb_o = use_rk ? fwd_sel(rk, rf_rdata_b_i) : imm;
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // from decode
    input  wire                    dec_valid_i,
    input  core_cfg_pkg::addr_t    dec_pc_i,
    input  core_cfg_pkg::word_t    dec_inst_i,
    input  wire                    dec_wen_i,
    input  core_cfg_pkg::reg_idx_t dec_wnum_i,
    input  isa_pkg::alu_op_e       dec_op_i,
    input  core_cfg_pkg::word_t    dec_opa_i,
    input  core_cfg_pkg::word_t    dec_opb_i,
    // bypass back to decode
    output logic                   ex_fwd_valid_o,
    output logic                   ex_fwd_wen_o,
    output core_cfg_pkg::reg_idx_t ex_fwd_wnum_o,
    output core_cfg_pkg::word_t    ex_fwd_data_o,
    // to result stage
    output logic                   ex_valid_o,
    output core_cfg_pkg::addr_t    ex_pc_o,
    output core_cfg_pkg::word_t    ex_inst_o,
    output logic                   ex_wen_o,
    output core_cfg_pkg::reg_idx_t ex_wnum_o,
    output core_cfg_pkg::word_t    ex_result_o
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    logic     valid_q;
    logic     wen_q;
    addr_t    pc_q;
    word_t    inst_q;
    reg_idx_t wnum_q;
    alu_op_e  op_q;
    word_t    opa_q;
    word_t    opb_q;
    word_t    alu_res;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
        end else begin
            valid_q <= dec_valid_i;
            wen_q   <= dec_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_q   <= dec_pc_i;
        inst_q <= dec_inst_i;
        wnum_q <= dec_wnum_i;
        op_q   <= dec_op_i;
        opa_q  <= dec_opa_i;
        opb_q  <= dec_opb_i;
    end

    // 32-bit wraparound arithmetic
    always_comb begin
        case (op_q)
            ALU_SUB: alu_res = opa_q - opb_q;
            ALU_AND: alu_res = opa_q & opb_q;
            ALU_OR:  alu_res = opa_q | opb_q;
            ALU_XOR: alu_res = opa_q ^ opb_q;
            // upper immediate already shifted by decode
            ALU_LUI: alu_res = opb_q;
            default: alu_res = opa_q + opb_q;
        endcase
    end

    // same result on the bypass and towards the result register
    assign ex_fwd_valid_o = valid_q;
    assign ex_fwd_wen_o   = wen_q;
    assign ex_fwd_wnum_o  = wnum_q;
    assign ex_fwd_data_o  = alu_res;

    assign ex_valid_o  = valid_q;
    assign ex_pc_o     = pc_q;
    assign ex_inst_o   = inst_q;
    assign ex_wen_o    = wen_q;
    assign ex_wnum_o   = wnum_q;
    assign ex_result_o = alu_res;

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter core_cfg_pkg::addr_t BOOT_PC = 32'h1c00_0000
) (
    input  wire                 clk,
    input  wire                 rst_n_i,
    // wishbone classic read master
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output core_cfg_pkg::addr_t wb_adr_o,
    input  core_cfg_pkg::word_t wb_dat_i,
    input  wire                 wb_ack_i,
    // fetched instruction to decode
    output logic                fetch_valid_o,
    output core_cfg_pkg::addr_t fetch_pc_o,
    output core_cfg_pkg::word_t fetch_inst_o
);
    import core_cfg_pkg::*;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_BUSY
    } fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        pc_q;
    logic         req;
    logic         accept;

    // bus request open in busy
    assign req    = (state_q == FETCH_BUSY);
    // transfer ends at the edge where ack is seen
    assign accept = req & wb_ack_i;

    // idle only right after reset, then one request after another
    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: state_d = FETCH_BUSY;
            default:    state_d = state_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FETCH_IDLE;
            pc_q    <= BOOT_PC;
        end else begin
            state_q <= state_d;
            // sequential fetch only
            if (accept) begin
                pc_q <= pc_q + addr_t'(4);
            end
        end
    end

    // cyc and stb move together, address held until ack
    assign wb_cyc_o = req;
    assign wb_stb_o = req;
    assign wb_adr_o = pc_q;

    // instruction handed over in the ack cycle
    assign fetch_valid_o = accept;
    assign fetch_pc_o    = pc_q;
    assign fetch_inst_o  = wb_dat_i;

endmodule

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // alu function chosen by decode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

    // 3R format, opcode in inst[31:15]
    // rk in [14:10], rj in [9:5], rd in [4:0]
    localparam logic [16:0] OPC3R_ADD = 17'h00020;
    localparam logic [16:0] OPC3R_SUB = 17'h00022;
    localparam logic [16:0] OPC3R_AND = 17'h00029;
    localparam logic [16:0] OPC3R_OR  = 17'h0002a;
    localparam logic [16:0] OPC3R_XOR = 17'h0002b;

    // 2RI12 format, opcode in inst[31:22]
    // si12 in [21:10]
    localparam logic [9:0] OPC_ADDI = 10'h00a;

    // 1RI20 format, opcode in inst[31:25]
    // si20 in [24:5]
    localparam logic [6:0] OPC_LU12I = 7'h0a;

endpackage

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // two combinational read ports
    input  core_cfg_pkg::reg_idx_t raddr_a_i,
    input  core_cfg_pkg::reg_idx_t raddr_b_i,
    output core_cfg_pkg::word_t    rdata_a_o,
    output core_cfg_pkg::word_t    rdata_b_o,
    // one write port
    input  wire                    we_i,
    input  core_cfg_pkg::reg_idx_t waddr_i,
    input  core_cfg_pkg::word_t    wdata_i
);
    import core_cfg_pkg::*;

    word_t regs_q [REG_COUNT];

    // r0 stays zero since result stage never writes it
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write not visible here, decode forwards it
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== src/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire                    clk,
    input  wire                    rst_n_i,
    // from execute
    input  wire                    ex_valid_i,
    input  core_cfg_pkg::addr_t    ex_pc_i,
    input  core_cfg_pkg::word_t    ex_inst_i,
    input  wire                    ex_wen_i,
    input  core_cfg_pkg::reg_idx_t ex_wnum_i,
    input  core_cfg_pkg::word_t    ex_result_i,
    // bypass back to decode
    output logic                   res_fwd_valid_o,
    output logic                   res_fwd_wen_o,
    output core_cfg_pkg::reg_idx_t res_fwd_wnum_o,
    output core_cfg_pkg::word_t    res_fwd_data_o,
    // register file write port
    output logic                   rf_we_o,
    output core_cfg_pkg::reg_idx_t rf_waddr_o,
    output core_cfg_pkg::word_t    rf_wdata_o,
    // commit trace
    output logic                   commit_valid_o,
    output core_cfg_pkg::addr_t    commit_pc_o,
    output core_cfg_pkg::word_t    commit_inst_o,
    output logic                   commit_wen_o,
    output core_cfg_pkg::reg_idx_t commit_wnum_o,
    output core_cfg_pkg::word_t    commit_wdata_o
);
    import core_cfg_pkg::*;

    logic     valid_q;
    logic     wen_q;
    addr_t    pc_q;
    word_t    inst_q;
    reg_idx_t wnum_q;
    word_t    data_q;
    logic     we;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
        end else begin
            valid_q <= ex_valid_i;
            wen_q   <= ex_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_q   <= ex_pc_i;
        inst_q <= ex_inst_i;
        wnum_q <= ex_wnum_i;
        data_q <= ex_result_i;
    end

    // register written at the end of the commit cycle
    assign we = valid_q & wen_q;

    assign res_fwd_valid_o = valid_q;
    assign res_fwd_wen_o   = wen_q;
    assign res_fwd_wnum_o  = wnum_q;
    assign res_fwd_data_o  = data_q;

    assign rf_we_o    = we;
    assign rf_waddr_o = wnum_q;
    assign rf_wdata_o = data_q;

    // one cycle per instruction, like a debug write-back port
    assign commit_valid_o = valid_q;
    assign commit_pc_o    = pc_q;
    assign commit_inst_o  = inst_q;
    assign commit_wen_o   = we;
    assign commit_wnum_o  = wnum_q;
    assign commit_wdata_o = data_q;

endmodule

`default_nettype wire
